// File: verilog/motor_pkg.sv
package motor_pkg;

	// the peripheral occupies four consecutive byte addresses
	localparam logic [7:0] motor_base  = 8'h00;
	localparam logic [7:0] motor_addr  = motor_base;          // direction nibble for the two bridges
	localparam logic [7:0] enable_addr = motor_base + 8'd1;   // bit 0 enables the driver chip
	localparam logic [7:0] pwm0_addr   = motor_base + 8'd2;   // compare value of channel 0
	localparam logic [7:0] pwm1_addr   = motor_base + 8'd3;   // compare value of channel 1

	// number of registers behind the bus, one select line each
	localparam int unsigned reg_count = 4;

	// width of the direction field, two input pairs of an H-bridge
	localparam int unsigned motor_width = 4;

	// the prescaler counts 0 to scale_factor, so one tick every 126 clocks
	localparam int unsigned scale_factor   = 125;
	localparam int unsigned prescale_width = $clog2(scale_factor + 1);

	// the period counter and both compare values share this width
	localparam int unsigned        pwm_width = 8;
	localparam logic [pwm_width-1:0] pwm_top = '1;   // last count before the period wraps

	// register request as seen on the processor strobes
	typedef struct packed {
		logic [7:0] address;
		logic [7:0] din;
		logic       w_en;
		logic       r_en;
	} bus_req_t;

	// current contents of the register file
	typedef struct packed {
		logic [motor_width-1:0] motor;
		logic                   enable;
		logic [pwm_width-1:0]   cmpr0;
		logic [pwm_width-1:0]   cmpr1;
	} motor_cfg_t;

endpackage

// File: verilog/motor_regs.sv
`timescale 1ns/1ns

module motor_regs
	import motor_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  bus_req_t   req,
	output motor_cfg_t cfg,
	output logic [7:0] dout
);

	logic [reg_count-1:0] sel;       // one line per register, set on an exact address match
	logic                 rd_hit;    // the current address maps to some register
	logic [7:0]           rd_data;   // value that a read at this address returns

	// full eight bit compare, so aliases such as 8'h04 never hit
	always_comb begin
		sel    = '0;
		sel[0] = (req.address == motor_addr);
		sel[1] = (req.address == enable_addr);
		sel[2] = (req.address == pwm0_addr);
		sel[3] = (req.address == pwm1_addr);
	end

	assign rd_hit = |sel;

	// read multiplexer, narrow fields come back zero-extended
	always_comb begin
		rd_data = '0;
		if (sel[0]) begin
			rd_data = {{(8 - motor_width){1'b0}}, cfg.motor};
		end
		else if (sel[1]) begin
			rd_data = {7'b0, cfg.enable};
		end
		else if (sel[2]) begin
			rd_data = cfg.cmpr0;
		end
		else if (sel[3]) begin
			rd_data = cfg.cmpr1;
		end
	end

	// register file, written one strobe at a time
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cfg.motor  <= '0;
			cfg.enable <= 1'b1;   // the driver comes up enabled
			cfg.cmpr0  <= '0;
			cfg.cmpr1  <= '0;
		end
		else if (req.w_en) begin
			if (sel[0]) begin
				cfg.motor <= req.din[motor_width-1:0];   // only the low nibble is kept
			end
			if (sel[1]) begin
				cfg.enable <= req.din[0];
			end
			if (sel[2]) begin
				cfg.cmpr0 <= req.din;
			end
			if (sel[3]) begin
				cfg.cmpr1 <= req.din;
			end
		end
	end

	// read data port
	// an unmapped read leaves the last value on dout
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dout <= '0;
		end
		else if (req.r_en && rd_hit) begin
			dout <= rd_data;   // a same-cycle write shows up on the next read
		end
	end

endmodule

// File: verilog/pwm_gen.sv
`timescale 1ns/1ns

module pwm_gen
	import motor_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [pwm_width-1:0] cmpr0,
	input  logic [pwm_width-1:0] cmpr1,
	output logic [1:0]           pwm_raw,
	output logic                 period_start
);

	logic [prescale_width-1:0] prescaler;   // clock divider in front of the period counter
	logic                      tick;        // one clock wide, once every scale_factor+1 clocks
	logic [pwm_width-1:0]      count;       // position inside the current period
	logic                      wrap;        // tick on which count rolls over to zero
	logic [pwm_width-1:0]      cmpr [2];    // compare values indexed by channel

	assign cmpr[0] = cmpr0;
	assign cmpr[1] = cmpr1;

	assign tick = (prescaler == prescale_width'(scale_factor));
	assign wrap = tick && (count == pwm_top);

	// prescaler runs freely from reset
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			prescaler <= '0;
		end
		else if (tick) begin
			prescaler <= '0;
		end
		else begin
			prescaler <= prescaler + 1'b1;
		end
	end

	// period counter, the natural overflow gives 256 ticks per period
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			count <= '0;
		end
		else if (tick) begin
			count <= count + 1'b1;
		end
	end

	// high in the first cycle of count 0, in step with the set of pwm_raw
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			period_start <= 1'b0;
		end
		else begin
			period_start <= wrap;
		end
	end

	// both channels are set at the wrap and each clears on its own match.
	// the set wins over a match at count 255, so a compare of 255 stays high
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pwm_raw <= '0;
		end
		else if (wrap) begin
			pwm_raw <= '1;
		end
		else if (tick) begin
			for (int i = 0; i < 2; i++) begin
				if (count == cmpr[i]) begin
					pwm_raw[i] <= 1'b0;   // high for cmpr+1 ticks in all
				end
			end
		end
	end

endmodule

// File: verilog/motor_output.sv
`timescale 1ns/1ns

module motor_output
	import motor_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [motor_width-1:0] motor_req,
	input  logic                   enable_req,
	input  logic [1:0]             pwm_raw,
	input  logic                   period_start,
	output logic [1:0]             pwm,
	output logic [motor_width-1:0] motor,
	output logic                   enable
);

	// gated PWM, both lines stay low while the driver is disabled
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pwm <= '0;
		end
		else begin
			pwm <= pwm_raw & {2{enable_req}};
		end
	end

	// the bridge inputs only change at a period boundary, so a direction
	// change never lands in the middle of a pulse.
	// pwm rises on the same edge at which the new nibble appears
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			motor <= '0;
		end
		else if (period_start) begin
			motor <= motor_req;
		end
	end

	// enable pin of the external driver chip
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			enable <= 1'b1;   // matches the reset value of the enable register
		end
		else begin
			enable <= enable_req;
		end
	end

endmodule

// File: verilog/motor_top.sv
`timescale 1ns/1ns

module motor_top
	import motor_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [7:0]             address,
	input  logic [7:0]             din,
	input  logic                   w_en,
	input  logic                   r_en,
	output logic [7:0]             dout,
	output logic [1:0]             pwm,
	output logic [motor_width-1:0] motor,
	output logic                   enable
);

	bus_req_t   req;            // processor strobes gathered into one request
	motor_cfg_t cfg;            // live register contents
	logic [1:0] pwm_raw;        // ungated compare outputs
	logic       period_start;   // first cycle of a new PWM period

	assign req = '{address: address, din: din, w_en: w_en, r_en: r_en};

	// register file and read port
	motor_regs u_regs (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (req),
		.cfg   (cfg),
		.dout  (dout)
	);

	// timebase and the two compare channels
	pwm_gen u_pwm (
		.clk          (clk),
		.rst_n        (rst_n),
		.cmpr0        (cfg.cmpr0),
		.cmpr1        (cfg.cmpr1),
		.pwm_raw      (pwm_raw),
		.period_start (period_start)
	);

	// enable gating and deferred direction load
	motor_output u_out (
		.clk          (clk),
		.rst_n        (rst_n),
		.motor_req    (cfg.motor),
		.enable_req   (cfg.enable),
		.pwm_raw      (pwm_raw),
		.period_start (period_start),
		.pwm          (pwm),
		.motor        (motor),
		.enable       (enable)
	);

endmodule

// File: tb/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;   // 4 ns period
	end

	initial begin
		rst_n = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);   // release between edges, like every other input
		rst_n = 1'b1;
	end

endmodule

// File: tb/tb_checker.sv
`timescale 1ns/1ns

module tb_checker
	import motor_pkg::*;
(
	input  logic        clk,
	input  logic [7:0]  dout,
	input  logic [1:0]  pwm,
	input  logic [3:0]  motor,
	input  logic        enable,
	input  logic        start,   // test request from the stimulus side
	input  logic [3:0]  kind,
	input  logic [15:0] arg_a,
	input  logic [15:0] arg_b,
	output logic        done,
	output int          fail_count
);

	int          pass_count;
	logic [15:0] high [2];   // clocks each pwm line spent high in the window
	logic        prev;       // pwm[0] at the previous falling edge
	bit          ok;

	function automatic bit compare_value(string name, logic [15:0] expected,
			logic [15:0] actual);
		if (expected !== actual) begin
			$display("** Error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
			return 1'b0;
		end
		return 1'b1;
	endfunction

	// every sample is taken on a falling edge, half a cycle away from DUT updates
	task automatic run_check();
		int period;
		int i;
		period = (scale_factor + 1) << pwm_width;   // 256 ticks of 126 clocks
		ok = 1'b1;
		case (kind)
			4'd0: $display("checks run %0d, passed %0d, failed %0d",
				pass_count + fail_count, pass_count, fail_count);
			4'd2, 4'd6: begin
				@(negedge clk);
				ok = compare_value(kind == 4'd2 ? "dout" : "enable", arg_b,
					kind == 4'd2 ? 16'(dout) : 16'(enable));
			end
			4'd3: begin
				high[0] = '0;
				high[1] = '0;
				repeat (period) @(negedge clk);   // a period after a write may be mixed
				prev = pwm[0];
				for (i = 0; i < period && !(pwm[0] && !prev); i++) begin
					prev = pwm[0];
					@(negedge clk);
				end
				repeat (period) begin
					high[0] += 16'(pwm[0]);
					high[1] += 16'(pwm[1]);
					@(negedge clk);
				end
				ok = compare_value("pwm[0] high clocks", arg_a, high[0]);
				ok = compare_value("pwm[1] high clocks", arg_b, high[1]) && ok;
			end
			4'd5: begin
				@(negedge clk);
				prev = pwm[0];
				// old nibble until pwm[0] rises, the new one from that edge on
				while (ok && !(pwm[0] && !prev)) begin
					ok = compare_value("motor", arg_a, 16'(motor));
					prev = pwm[0];
					@(negedge clk);
				end
				if (ok) begin
					ok = compare_value("motor", arg_b, 16'(motor));
				end
			end
			default: begin
				$display("unknown operation %0d in the cases file", kind);
				ok = 1'b0;
			end
		endcase
		if (kind != 4'd0) begin
			if (ok) begin
				pass_count++;
			end
			else begin
				fail_count++;
			end
			$display("test %0d (op %0d, %h %h) %s", pass_count + fail_count, kind, arg_a, arg_b,
				ok ? "ok" : "wrong");
		end
	endtask

	// four phase handshake, start is read on rising edges and done is set on them
	initial begin
		done       = 1'b0;
		fail_count = 0;
		pass_count = 0;
		forever begin
			@(posedge clk);
			if (start) begin
				run_check();
				@(posedge clk);
				done = 1'b1;
				while (start) @(posedge clk);
				done = 1'b0;
			end
		end
	end

endmodule

// File: tb/tb_top.sv
`timescale 1ns/1ns

module tb_top
	import motor_pkg::*;
();

	logic        clk;
	logic        rst_n;
	logic [7:0]  address;
	logic [7:0]  din;
	logic        w_en;
	logic        r_en;
	logic [7:0]  dout;
	logic [1:0]  pwm;
	logic [3:0]  motor;
	logic        enable;
	logic        start;
	logic [3:0]  kind;
	logic [15:0] arg_a;
	logic [15:0] arg_b;
	logic        done;
	int          fail_count;
	logic [15:0] cases [256];   // three words per test, the operation and two arguments
	int unsigned budget;        // watchdog limit in clocks

	tb_clock u_clk (.clk(clk), .rst_n(rst_n));

	motor_top UUT (
		.clk     (clk),
		.rst_n   (rst_n),
		.address (address),
		.din     (din),
		.w_en    (w_en),
		.r_en    (r_en),
		.dout    (dout),
		.pwm     (pwm),
		.motor   (motor),
		.enable  (enable)
	);

	tb_checker u_chk (
		.clk        (clk),
		.dout       (dout),
		.pwm        (pwm),
		.motor      (motor),
		.enable     (enable),
		.start      (start),
		.kind       (kind),
		.arg_a      (arg_a),
		.arg_b      (arg_b),
		.done       (done),
		.fail_count (fail_count)
	);

	// one strobe cycle, driven from a falling edge
	task automatic bus_access(input logic [7:0] addr, input logic [7:0] data, input logic write);
		@(negedge clk);
		address = addr;
		din     = data;
		w_en    = write;
		r_en    = !write;
		@(negedge clk);
		w_en = 1'b0;
		r_en = 1'b0;
	endtask

	// a falling pwm[0] is at least one tick away from the next period start
	task automatic wait_pwm0_fall();
		logic last;
		@(negedge clk);
		last = pwm[0];
		@(negedge clk);
		while (!(last && !pwm[0])) begin
			last = pwm[0];
			@(negedge clk);
		end
	endtask

	task automatic request_check(input logic [3:0] k, input logic [15:0] a, input logic [15:0] b);
		kind  = k;
		arg_a = a;
		arg_b = b;
		start = 1'b1;
		@(negedge clk);
		while (!done) @(negedge clk);
		start = 1'b0;
		while (done) @(negedge clk);
	endtask

	// periods that the cases need, with a fifth added as margin
	function automatic int unsigned watchdog_clocks();
		int unsigned periods;
		logic [7:0]  idx;
		periods = 1;
		idx     = '0;
		while (cases[idx] != 16'h0) begin
			case (cases[idx])
				16'h3: periods += 3;
				16'h4: periods += 32'(cases[idx + 8'd1]);
				16'h5: periods += 2;
				default: ;
			endcase
			idx += 8'd3;
		end
		periods += periods / 5 + 1;
		return periods * ((scale_factor + 1) << pwm_width);
	endfunction

	initial begin
		logic [7:0]  idx;
		logic [15:0] op;
		logic [15:0] a;
		logic [15:0] b;
		address = '0;
		din     = '0;
		w_en    = 1'b0;
		r_en    = 1'b0;
		start   = 1'b0;
		kind    = '0;
		arg_a   = '0;
		arg_b   = '0;
		$readmemh("tb/motor_cases.txt", cases);
		budget = watchdog_clocks();
		wait (rst_n);
		idx = '0;
		while (cases[idx] != 16'h0) begin
			op = cases[idx];
			a  = cases[idx + 8'd1];
			b  = cases[idx + 8'd2];
			case (op)
				16'h1: bus_access(a[7:0], b[7:0], 1'b1);
				16'h2: begin
					bus_access(a[7:0], 8'h00, 1'b0);
					request_check(4'd2, a, b);
				end
				16'h4: repeat (int'(a) * ((scale_factor + 1) << pwm_width)) @(negedge clk);
				16'h5: begin
					wait_pwm0_fall();
					bus_access(motor_addr, b[7:0], 1'b1);
					request_check(4'd5, a, b);
				end
				default: request_check(op[3:0], a, b);   // duty and enable pin checks
			endcase
			idx += 8'd3;
		end
		request_check(4'd0, '0, '0);   // checker prints the closing counts
		if (fail_count == 0) begin
			$display("TESTS PASSED");
		end
		else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	initial begin
		wait (budget != 0);
		repeat (budget) @(posedge clk);
		$display("watchdog expired after %0d clocks before the cases were finished", budget);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: tb/motor_cases.txt
// columns: operation, first argument, second argument, all hex
// 1 write addr data, 2 read addr expected, 3 duty clocks pwm0 pwm1, 4 wait periods,
// 5 direction old new, 6 enable pin expected in the second column, 0 end of cases
2 0000 0000
2 0001 0001
2 0002 0000
2 0003 0000
6 0000 0001
1 0000 00a5
2 0000 0005
1 0001 00fe
2 0001 0000
1 0001 0001
1 0002 003c
1 0003 00c3
2 0003 00c3
1 0004 0077
1 00ff 0055
2 0000 0005
2 0001 0001
2 0002 003c
2 0004 003c
2 00ff 003c
2 0003 00c3
1 0002 003f
1 0003 00ff
3 1f80 7e00
1 0002 0000
1 0003 007f
3 007e 3f00
1 0001 0000
6 0000 0000
3 0000 0000
1 0001 0001
6 0000 0001
3 007e 3f00
5 0005 000a
1 0002 0080
5 000a 0003
4 0001 0000
2 0000 0003
3 3f7e 3f00
0 0000 0000

// File: filelist.f
verilog/motor_pkg.sv
verilog/motor_regs.sv
verilog/pwm_gen.sv
verilog/motor_output.sv
verilog/motor_top.sv
tb/tb_clock.sv
tb/tb_checker.sv
tb/tb_top.sv

// File: Makefile
VERILATOR  = verilator
TOP        = tb_top
RTL_TOP    = motor_top
FILELIST   = filelist.f
SIM_FLAGS  = --binary --timing -j 0
LINT_FLAGS = --lint-only -Wall --timing
LOG        = sim.log
SIM_EXE    = obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	$(SIM_EXE) | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
